// File: Makefile
SIM = obj_dir/sim_id_stage
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_id_stage -f files.f -o sim_id_stage

run: compile
	./$(SIM) | tee $(LOG)
	grep -q "\*\* PASS \*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: files.f
hdl/rv_isa_pkg.sv
hdl/id_ctrl_pkg.sv
hdl/id_control.sv
hdl/imm_gen.sv
hdl/target_gen.sv
hdl/inst_pipe.sv
hdl/id_stage.sv
sim/tb_clock.sv
sim/id_stage_assert.sv
sim/tb_id_stage.sv

// File: hdl/id_control.sv
`timescale 1ns/1ps
`default_nettype none

module id_control (
    input  wire rv_isa_pkg::inst_u     inst,
    input  wire rv_isa_pkg::inst_u     ex_inst,
    input  wire rv_isa_pkg::inst_u     mem_inst,
    input  wire rv_isa_pkg::inst_u     wb_inst,
    output id_ctrl_pkg::id_ctrl_t      ctrl,
    output logic                       stall
);

    // True when a later-stage instruction updates its rd
    function automatic logic writes_rd(input rv_isa_pkg::inst_u i);
        logic [6:0] opc;
        opc = i.r_fmt.opcode;
        return (opc != rv_isa_pkg::OPC_STORE) &&
               (opc != rv_isa_pkg::OPC_BRANCH) &&
               (opc != rv_isa_pkg::OPC_SYSTEM) &&
               (i.r_fmt.rd != 5'd0) &&
               (i != rv_isa_pkg::NOP_INST);
    endfunction

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       has_rs1;
    logic       has_rs2;
    logic       is_store;
    logic       ex_wr;
    logic       mem_wr;
    logic       wb_wr;
    logic       ex_load;
    logic       load_rs1_hit;
    logic       load_rs2_hit;

    assign opcode = inst.r_fmt.opcode;
    assign funct3 = inst.r_fmt.funct3;
    assign rs1    = inst.r_fmt.rs1;
    assign rs2    = inst.r_fmt.rs2;

    assign has_rs1 = (opcode != rv_isa_pkg::OPC_LUI) &&
                     (opcode != rv_isa_pkg::OPC_AUIPC) &&
                     (opcode != rv_isa_pkg::OPC_JAL);
    assign has_rs2 = (opcode == rv_isa_pkg::OPC_ARI_RTYPE) ||
                     (opcode == rv_isa_pkg::OPC_STORE) ||
                     (opcode == rv_isa_pkg::OPC_BRANCH);
    assign is_store = (opcode == rv_isa_pkg::OPC_STORE);

    assign ex_wr  = writes_rd(ex_inst);
    assign mem_wr = writes_rd(mem_inst);
    assign wb_wr  = writes_rd(wb_inst);

    // Load in EX whose result is not ready for ID
    assign ex_load      = (ex_inst.r_fmt.opcode == rv_isa_pkg::OPC_LOAD) && ex_wr;
    assign load_rs1_hit = ex_load && (rs1 == ex_inst.r_fmt.rd);
    assign load_rs2_hit = ex_load && (rs2 == ex_inst.r_fmt.rd);

    // Only the address register of a store can stall
    assign stall = is_store ? load_rs1_hit :
                   ((has_rs1 && load_rs1_hit) || (has_rs2 && load_rs2_hit));

    always_comb begin
        ctrl.imm_sel = id_ctrl_pkg::IMM_NONE;
        ctrl.tgt_sel = id_ctrl_pkg::TGT_NONE;
        ctrl.tgt_en  = 1'b0;

        // Youngest producer wins
        if (ex_wr && rs1 == ex_inst.r_fmt.rd) begin
            ctrl.fwd_sel = id_ctrl_pkg::FWD_EX;
        end else if (mem_wr && rs1 == mem_inst.r_fmt.rd) begin
            ctrl.fwd_sel = id_ctrl_pkg::FWD_MEM;
        end else if (wb_wr && rs1 == wb_inst.r_fmt.rd) begin
            ctrl.fwd_sel = id_ctrl_pkg::FWD_WB;
        end else begin
            ctrl.fwd_sel = id_ctrl_pkg::FWD_RF;
        end

        case (opcode)
            rv_isa_pkg::OPC_ARI_ITYPE: begin
                // Shift amount sits in the low immediate bits
                ctrl.imm_sel = id_ctrl_pkg::IMM_I;
            end
            rv_isa_pkg::OPC_LOAD: begin
                case (funct3)
                    rv_isa_pkg::FNC_LB, rv_isa_pkg::FNC_LH, rv_isa_pkg::FNC_LW,
                    rv_isa_pkg::FNC_LBU, rv_isa_pkg::FNC_LHU:
                        ctrl.imm_sel = id_ctrl_pkg::IMM_I;
                    default: ;
                endcase
            end
            rv_isa_pkg::OPC_STORE: begin
                case (funct3)
                    rv_isa_pkg::FNC_SB, rv_isa_pkg::FNC_SH, rv_isa_pkg::FNC_SW:
                        ctrl.imm_sel = id_ctrl_pkg::IMM_S;
                    default: ;
                endcase
            end
            rv_isa_pkg::OPC_BRANCH: begin
                case (funct3)
                    rv_isa_pkg::FNC_BEQ, rv_isa_pkg::FNC_BNE, rv_isa_pkg::FNC_BLT,
                    rv_isa_pkg::FNC_BGE, rv_isa_pkg::FNC_BLTU, rv_isa_pkg::FNC_BGEU: begin
                        ctrl.imm_sel = id_ctrl_pkg::IMM_B;
                        ctrl.tgt_sel = id_ctrl_pkg::TGT_BR;
                        ctrl.tgt_en  = 1'b1;
                    end
                    default: ;
                endcase
            end
            rv_isa_pkg::OPC_JAL: begin
                ctrl.imm_sel = id_ctrl_pkg::IMM_J;
                ctrl.tgt_sel = id_ctrl_pkg::TGT_JAL;
                ctrl.tgt_en  = 1'b1;
            end
            rv_isa_pkg::OPC_JALR: begin
                ctrl.imm_sel = id_ctrl_pkg::IMM_I;
                ctrl.tgt_sel = id_ctrl_pkg::TGT_JALR;
                // Wait for the load to reach MEM
                ctrl.tgt_en  = !load_rs1_hit;
            end
            rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: begin
                ctrl.imm_sel = id_ctrl_pkg::IMM_U;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/id_ctrl_pkg.sv
`default_nettype none

package id_ctrl_pkg;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_sel_e;

    // Base of the target adder
    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_BR,
        TGT_JAL,
        TGT_JALR
    } tgt_sel_e;

    // Where the rs1 value for JALR comes from
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        imm_sel_e imm_sel;
        tgt_sel_e tgt_sel;
        fwd_sel_e fwd_sel;
        logic     tgt_en;
    } id_ctrl_t;

endpackage

`default_nettype wire

// File: hdl/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire rv_isa_pkg::inst_u inst,
    input  wire logic [31:0]       pc,
    input  wire logic [31:0]       rf_rs1,
    input  wire logic [31:0]       ex_result,
    input  wire logic [31:0]       mem_result,
    input  wire logic [31:0]       wb_result,
    output logic [31:0]            imm,
    output logic [31:0]            target,
    output logic                   target_valid,
    output logic                   stall
);

    rv_isa_pkg::inst_u     ex_inst;
    rv_isa_pkg::inst_u     mem_inst;
    rv_isa_pkg::inst_u     wb_inst;
    id_ctrl_pkg::id_ctrl_t ctrl;

    id_control i_id_control (
        .inst     (inst),
        .ex_inst  (ex_inst),
        .mem_inst (mem_inst),
        .wb_inst  (wb_inst),
        .ctrl     (ctrl),
        .stall    (stall)
    );

    imm_gen i_imm_gen (
        .inst (inst),
        .ctrl (ctrl),
        .imm  (imm)
    );

    target_gen i_target_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .pc           (pc),
        .imm          (imm),
        .rf_rs1       (rf_rs1),
        .ex_result    (ex_result),
        .mem_result   (mem_result),
        .wb_result    (wb_result),
        .target       (target),
        .target_valid (target_valid)
    );

    inst_pipe i_inst_pipe (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst     (inst),
        .stall    (stall),
        .ex_inst  (ex_inst),
        .mem_inst (mem_inst),
        .wb_inst  (wb_inst)
    );

endmodule

`default_nettype wire

// File: hdl/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  wire rv_isa_pkg::inst_u     inst,
    input  wire id_ctrl_pkg::id_ctrl_t ctrl,
    output logic [31:0]                imm
);

    logic i_sign;
    logic s_sign;
    logic u_sign;

    // Bit 31 viewed through each layout
    assign i_sign = inst.i_fmt.imm[11];
    assign s_sign = inst.s_fmt.imm_hi[6];
    assign u_sign = inst.u_fmt.imm[19];

    always_comb begin
        case (ctrl.imm_sel)
            id_ctrl_pkg::IMM_I:
                imm = {{20{i_sign}}, inst.i_fmt.imm};
            id_ctrl_pkg::IMM_S:
                imm = {{20{s_sign}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
            id_ctrl_pkg::IMM_B:
                imm = {{20{s_sign}}, inst.s_fmt.imm_lo[0], inst.s_fmt.imm_hi[5:0],
                       inst.s_fmt.imm_lo[4:1], 1'b0};
            id_ctrl_pkg::IMM_U:
                imm = {inst.u_fmt.imm, 12'd0};
            // imm[20|10:1|11|19:12] in the upper 20 bits
            id_ctrl_pkg::IMM_J:
                imm = {{12{u_sign}}, inst.u_fmt.imm[7:0], inst.u_fmt.imm[8],
                       inst.u_fmt.imm[18:9], 1'b0};
            default:
                imm = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/inst_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module inst_pipe (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire rv_isa_pkg::inst_u inst,
    input  wire                    stall,
    output rv_isa_pkg::inst_u      ex_inst,
    output rv_isa_pkg::inst_u      mem_inst,
    output rv_isa_pkg::inst_u      wb_inst
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_inst  <= rv_isa_pkg::NOP_INST;
            mem_inst <= rv_isa_pkg::NOP_INST;
            wb_inst  <= rv_isa_pkg::NOP_INST;
        end else begin
            // Bubble into EX, ID holds its instruction
            if (stall) begin
                ex_inst <= rv_isa_pkg::NOP_INST;
            end else begin
                ex_inst <= inst;
            end
            mem_inst <= ex_inst;
            wb_inst  <= mem_inst;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_ARI_ITYPE = 7'b0010011;
    localparam logic [6:0] OPC_ARI_RTYPE = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    // Branch funct3
    localparam logic [2:0] FNC_BEQ  = 3'b000;
    localparam logic [2:0] FNC_BNE  = 3'b001;
    localparam logic [2:0] FNC_BLT  = 3'b100;
    localparam logic [2:0] FNC_BGE  = 3'b101;
    localparam logic [2:0] FNC_BLTU = 3'b110;
    localparam logic [2:0] FNC_BGEU = 3'b111;

    // Load funct3
    localparam logic [2:0] FNC_LB  = 3'b000;
    localparam logic [2:0] FNC_LH  = 3'b001;
    localparam logic [2:0] FNC_LW  = 3'b010;
    localparam logic [2:0] FNC_LBU = 3'b100;
    localparam logic [2:0] FNC_LHU = 3'b101;

    // Store funct3
    localparam logic [2:0] FNC_SB = 3'b000;
    localparam logic [2:0] FNC_SH = 3'b001;
    localparam logic [2:0] FNC_SW = 3'b010;

    // Arithmetic funct3
    localparam logic [2:0] FNC_ADD_SUB = 3'b000;
    localparam logic [2:0] FNC_SLL     = 3'b001;
    localparam logic [2:0] FNC_SLT     = 3'b010;
    localparam logic [2:0] FNC_SLTU    = 3'b011;
    localparam logic [2:0] FNC_XOR     = 3'b100;
    localparam logic [2:0] FNC_SRL_SRA = 3'b101;
    localparam logic [2:0] FNC_OR      = 3'b110;
    localparam logic [2:0] FNC_AND     = 3'b111;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_INST = 32'h0000_0013;

    // One instruction word, four field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        // Also carries the B immediate
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        // Also carries the J immediate
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
    } inst_u;

endpackage

`default_nettype wire

// File: hdl/target_gen.sv
`timescale 1ns/1ps
`default_nettype none

module target_gen (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire id_ctrl_pkg::id_ctrl_t ctrl,
    input  wire logic [31:0]           pc,
    input  wire logic [31:0]           imm,
    input  wire logic [31:0]           rf_rs1,
    input  wire logic [31:0]           ex_result,
    input  wire logic [31:0]           mem_result,
    input  wire logic [31:0]           wb_result,
    output logic [31:0]                target,
    output logic                       target_valid
);

    logic [31:0] rs1_fwd;
    logic [31:0] base;
    logic [31:0] sum;
    logic        is_jalr;

    always_comb begin
        case (ctrl.fwd_sel)
            id_ctrl_pkg::FWD_EX:  rs1_fwd = ex_result;
            id_ctrl_pkg::FWD_MEM: rs1_fwd = mem_result;
            id_ctrl_pkg::FWD_WB:  rs1_fwd = wb_result;
            default:              rs1_fwd = rf_rs1;
        endcase
    end

    assign is_jalr = (ctrl.tgt_sel == id_ctrl_pkg::TGT_JALR);

    // Branches and JAL are PC relative
    assign base = is_jalr ? rs1_fwd : pc;
    assign sum  = base + imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            target_valid <= 1'b0;
        end else begin
            target_valid <= ctrl.tgt_en;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.tgt_en) begin
            // JALR drops the low bit
            target <= is_jalr ? {sum[31:1], 1'b0} : sum;
        end
    end

endmodule

`default_nettype wire

// File: sim/id_stage_assert.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_assert (
    input wire clk,
    input wire rst_n,
    input wire stall,
    input wire target_valid
);

    a_no_x: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown({stall, target_valid})
    ) else $error("stall or target_valid is unknown after reset");

    // Synchronous reset clears the valid flag on the next edge
    a_rst_valid: assert property (
        @(posedge clk)
        !rst_n |=> !target_valid
    ) else $error("target_valid high while in reset");

endmodule

bind id_stage id_stage_assert i_id_stage_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall        (stall),
    .target_valid (target_valid)
);

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held over five rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] rf_rs1;
    logic [31:0] ex_result;
    logic [31:0] mem_result;
    logic [31:0] wb_result;
    logic [31:0] imm;
    logic [31:0] target;
    logic        target_valid;
    logic        stall;

    logic [31:0] rng;
    int          mismatch_count;
    int          timeout_count;

    // Reference copy of the later stages
    logic [31:0] m_ex;
    logic [31:0] m_mem;
    logic [31:0] m_wb;
    logic [6:0]  opc;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        ld_ex;
    logic        reads1;
    logic        reads2;
    logic [31:0] src;
    logic        exp_stall;
    logic [31:0] exp_imm;
    logic        exp_en;
    logic [31:0] exp_next;
    logic        exp_valid;
    logic [31:0] exp_target;

    tb_clock i_tb_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    id_stage i_id_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst         (inst),
        .pc           (pc),
        .rf_rs1       (rf_rs1),
        .ex_result    (ex_result),
        .mem_result   (mem_result),
        .wb_result    (wb_result),
        .imm          (imm),
        .target       (target),
        .target_valid (target_valid),
        .stall        (stall)
    );

    function logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic is_writer(input logic [31:0] w);
        return (w[6:0] != rv_isa_pkg::OPC_STORE) && (w[6:0] != rv_isa_pkg::OPC_BRANCH) &&
               (w[6:0] != rv_isa_pkg::OPC_SYSTEM) && (w[11:7] != 5'd0) &&
               (w != rv_isa_pkg::NOP_INST);
    endfunction

    function automatic logic [31:0] expected_imm(input logic [31:0] w);
        case (w[6:0])
            rv_isa_pkg::OPC_ARI_ITYPE, rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_JALR:
                return {{20{w[31]}}, w[31:20]};
            rv_isa_pkg::OPC_STORE:
                return {{20{w[31]}}, w[31:25], w[11:7]};
            rv_isa_pkg::OPC_BRANCH:
                return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC:
                return {w[31:12], 12'd0};
            rv_isa_pkg::OPC_JAL:
                return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:
                return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] mk_i(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] ra,
                                         input logic [11:0] im);
        return {im, ra, f3, rd, op};
    endfunction

    function automatic logic [31:0] mk_s(input logic [2:0] f3, input logic [4:0] ra,
                                         input logic [4:0] rb, input logic [11:0] im);
        return {im[11:5], rb, ra, f3, im[4:0], rv_isa_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] mk_b(input logic [2:0] f3, input logic [4:0] ra,
                                         input logic [4:0] rb, input logic [12:0] im);
        return {im[12], im[10:5], rb, ra, f3, im[4:1], im[11], rv_isa_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] mk_j(input logic [4:0] rd, input logic [20:0] im);
        return {im[20], im[10:1], im[11], im[19:12], rd, rv_isa_pkg::OPC_JAL};
    endfunction

    always_comb begin
        opc    = inst[6:0];
        rs1    = inst[19:15];
        rs2    = inst[24:20];
        ld_ex  = (m_ex[6:0] == rv_isa_pkg::OPC_LOAD) && is_writer(m_ex);
        reads1 = (opc != rv_isa_pkg::OPC_LUI) && (opc != rv_isa_pkg::OPC_AUIPC) &&
                 (opc != rv_isa_pkg::OPC_JAL);
        reads2 = (opc == rv_isa_pkg::OPC_ARI_RTYPE) || (opc == rv_isa_pkg::OPC_STORE) ||
                 (opc == rv_isa_pkg::OPC_BRANCH);
        if (opc == rv_isa_pkg::OPC_STORE) begin
            exp_stall = ld_ex && (rs1 == m_ex[11:7]);
        end else begin
            exp_stall = ld_ex && ((reads1 && rs1 == m_ex[11:7]) ||
                                  (reads2 && rs2 == m_ex[11:7]));
        end
        exp_imm = expected_imm(inst);
        if (is_writer(m_ex) && m_ex[11:7] == rs1) begin
            src = ex_result;
        end else if (is_writer(m_mem) && m_mem[11:7] == rs1) begin
            src = mem_result;
        end else if (is_writer(m_wb) && m_wb[11:7] == rs1) begin
            src = wb_result;
        end else begin
            src = rf_rs1;
        end
        exp_en   = (opc == rv_isa_pkg::OPC_BRANCH) || (opc == rv_isa_pkg::OPC_JAL);
        exp_next = pc + exp_imm;
        if (opc == rv_isa_pkg::OPC_JALR) begin
            exp_en   = !(ld_ex && rs1 == m_ex[11:7]);
            exp_next = (src + exp_imm) & 32'hffff_fffe;
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            m_ex      <= rv_isa_pkg::NOP_INST;
            m_mem     <= rv_isa_pkg::NOP_INST;
            m_wb      <= rv_isa_pkg::NOP_INST;
            exp_valid <= 1'b0;
        end else begin
            m_ex      <= exp_stall ? rv_isa_pkg::NOP_INST : inst;
            m_mem     <= m_ex;
            m_wb      <= m_mem;
            exp_valid <= exp_en;
            if (exp_en) begin
                exp_target <= exp_next;
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] e,
                                   input logic [31:0] a);
        mismatch_count++;
        $display("Mismatch at %0t ns: %s expected %h actual %h", $time, name, e, a);
    endtask

    a_stall: assert property (@(posedge clk) disable iff (!rst_n) stall == exp_stall)
        else report_mismatch("stall", 32'($sampled(exp_stall)), 32'($sampled(stall)));
    a_imm: assert property (@(posedge clk) disable iff (!rst_n) imm == exp_imm)
        else report_mismatch("imm", $sampled(exp_imm), $sampled(imm));
    a_valid: assert property (@(posedge clk) disable iff (!rst_n) target_valid == exp_valid)
        else report_mismatch("target_valid", 32'($sampled(exp_valid)),
                             32'($sampled(target_valid)));
    a_target: assert property (@(posedge clk) disable iff (!rst_n)
                               exp_valid |-> target == exp_target)
        else report_mismatch("target", $sampled(exp_target), $sampled(target));

    // Starts on a falling edge and returns on the falling edge after ID accepts
    task automatic issue(input logic [31:0] w, input logic [31:0] p);
        int  n;
        logic st;
        inst       = w;
        pc         = p;
        rf_rs1     = next_rand();
        ex_result  = next_rand();
        mem_result = next_rand();
        wb_result  = next_rand();
        n = 0;
        forever begin
            #1;
            st = stall;
            @(negedge clk);
            if (!st) break;
            n++;
            if (n > 8) begin
                timeout_count++;
                $display("Timeout: stall did not fall within 8 cycles at %0t ns", $time);
                break;
            end
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  ld_f3 [5];
        logic [2:0]  br_f3 [6];
        int          n;
        rng            = 32'h2d0ce70e;
        mismatch_count = 0;
        timeout_count  = 0;
        ld_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        inst       = rv_isa_pkg::NOP_INST;
        pc         = 32'd0;
        rf_rs1     = 32'd0;
        ex_result  = 32'd0;
        mem_result = 32'd0;
        wb_result  = 32'd0;

        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            timeout_count++;
            $display("Timeout: reset was never released");
        end
        @(negedge clk);

        // Idle after reset
        repeat (4) issue(rv_isa_pkg::NOP_INST, 32'h100);

        // Random mix of all formats
        for (int i = 0; i < 40; i++) begin
            a = next_rand();
            b = next_rand();
            case (a[31:29])
                3'd0: issue(mk_i(rv_isa_pkg::OPC_ARI_ITYPE, a[2:0], a[7:3], a[12:8],
                                 b[11:0]), b);
                3'd1: issue(mk_i(rv_isa_pkg::OPC_LOAD, ld_f3[a[15:13] % 5], a[7:3],
                                 a[12:8], b[11:0]), b);
                3'd2: issue(mk_s(a[2:0] % 3, a[7:3], a[12:8], b[11:0]), b);
                3'd3: issue(mk_b(br_f3[a[15:13] % 6], a[7:3], a[12:8], b[12:0]), b);
                3'd4: issue({b[31:12], a[4:0], rv_isa_pkg::OPC_LUI}, b);
                3'd5: issue({b[31:12], a[4:0], rv_isa_pkg::OPC_AUIPC}, b);
                3'd6: issue(mk_j(a[4:0], b[20:0]), b);
                default: issue({7'd0, a[4:0], a[9:5], a[12:10], a[17:13],
                                rv_isa_pkg::OPC_ARI_RTYPE}, b);
            endcase
        end

        // JALR with producers in EX, MEM and WB
        issue(mk_i(rv_isa_pkg::OPC_ARI_ITYPE, 3'd0, 5'd5, 5'd1, 12'h10), 32'h200);
        issue(mk_i(rv_isa_pkg::OPC_JALR, 3'd0, 5'd1, 5'd5, 12'h7ff), 32'h204);
        issue(mk_i(rv_isa_pkg::OPC_ARI_ITYPE, 3'd0, 5'd6, 5'd1, 12'h10), 32'h208);
        issue(rv_isa_pkg::NOP_INST, 32'h20c);
        issue(mk_i(rv_isa_pkg::OPC_JALR, 3'd0, 5'd1, 5'd6, 12'h801), 32'h210);
        issue(mk_i(rv_isa_pkg::OPC_ARI_ITYPE, 3'd0, 5'd7, 5'd1, 12'h10), 32'h214);
        repeat (2) issue(rv_isa_pkg::NOP_INST, 32'h218);
        issue(mk_i(rv_isa_pkg::OPC_JALR, 3'd0, 5'd1, 5'd7, 12'h003), 32'h220);
        // Two producers of x8, youngest wins
        issue(mk_i(rv_isa_pkg::OPC_ARI_ITYPE, 3'd0, 5'd8, 5'd1, 12'h1), 32'h224);
        issue(mk_i(rv_isa_pkg::OPC_ARI_ITYPE, 3'd0, 5'd8, 5'd2, 12'h2), 32'h228);
        issue(mk_i(rv_isa_pkg::OPC_JALR, 3'd0, 5'd1, 5'd8, 12'h005), 32'h22c);
        // Producers that write nothing
        issue(mk_i(rv_isa_pkg::OPC_ARI_ITYPE, 3'd0, 5'd0, 5'd1, 12'h5), 32'h230);
        issue(mk_i(rv_isa_pkg::OPC_JALR, 3'd0, 5'd1, 5'd0, 12'h009), 32'h234);
        issue(mk_s(3'd2, 5'd1, 5'd2, 12'h005), 32'h238);
        issue(mk_i(rv_isa_pkg::OPC_JALR, 3'd0, 5'd1, 5'd5, 12'h00b), 32'h23c);

        // Load-use cases
        issue(mk_i(rv_isa_pkg::OPC_LOAD, 3'd2, 5'd9, 5'd1, 12'h0), 32'h300);
        issue(mk_i(rv_isa_pkg::OPC_JALR, 3'd0, 5'd1, 5'd9, 12'h021), 32'h304);
        issue(mk_i(rv_isa_pkg::OPC_LOAD, 3'd2, 5'd10, 5'd1, 12'h0), 32'h308);
        issue({7'd0, 5'd10, 5'd3, 3'd0, 5'd4, rv_isa_pkg::OPC_ARI_RTYPE}, 32'h30c);
        issue(mk_i(rv_isa_pkg::OPC_LOAD, 3'd2, 5'd11, 5'd1, 12'h0), 32'h310);
        issue(mk_s(3'd2, 5'd1, 5'd11, 12'h004), 32'h314);
        issue(mk_i(rv_isa_pkg::OPC_LOAD, 3'd2, 5'd0, 5'd1, 12'h0), 32'h318);
        issue(mk_i(rv_isa_pkg::OPC_JALR, 3'd0, 5'd1, 5'd0, 12'h041), 32'h31c);
        repeat (4) issue(rv_isa_pkg::NOP_INST, 32'h320);

        $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
